/* hw/exec_pkg.sv */
`default_nettype none

package exec_pkg;

  ////////////////////////////////////////////////////////////////////
  // widths and depths
  ////////////////////////////////////////////////////////////////////

  localparam int XLEN        = 32;
  localparam int REG_BITS    = 5;
  localparam int TAG_BITS    = 8;
  localparam int IN_DEPTH    = 4;
  localparam int OUT_DEPTH   = 4;
  localparam int MUL_STEPS   = 8;
  localparam int CREDIT_BITS = 4;

  // shifts take the low 5 bits of the second operand
  typedef enum logic [3:0] {
    OP_ADD   = 4'd0,
    OP_SUB   = 4'd1,
    OP_AND   = 4'd2,
    OP_OR    = 4'd3,
    OP_XOR   = 4'd4,
    OP_SLL   = 4'd5,
    OP_SRL   = 4'd6,
    OP_SRA   = 4'd7,
    OP_SLT   = 4'd8,
    OP_SLTU  = 4'd9,
    OP_MUL   = 4'd10,
    OP_MULHU = 4'd11
  } alu_op_e;

  ////////////////////////////////////////////////////////////////////
  // records passed between stages
  ////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [TAG_BITS-1:0] tag;
    alu_op_e             op;
    logic [REG_BITS-1:0] rd;
    logic [REG_BITS-1:0] rs1;
    logic [REG_BITS-1:0] rs2;
    logic                use_imm;
    logic [XLEN-1:0]     imm;
  } micro_op_t;

  typedef struct packed {
    logic                valid;
    logic [TAG_BITS-1:0] tag;
    alu_op_e             op;
    logic [REG_BITS-1:0] rd;
    logic [XLEN-1:0]     opnd_a;
    logic [XLEN-1:0]     opnd_b;
  } issue_t;

  typedef struct packed {
    logic                valid;
    logic [TAG_BITS-1:0] tag;
    logic [REG_BITS-1:0] rd;
    logic [XLEN-1:0]     value;
  } exec_result_t;

  typedef struct packed {
    logic                en;
    logic [REG_BITS-1:0] rd;
    logic [XLEN-1:0]     data;
  } reg_write_t;

  typedef struct packed {
    logic [TAG_BITS-1:0] tag;
    logic [REG_BITS-1:0] rd;
    logic [XLEN-1:0]     value;
  } result_t;

endpackage

`default_nettype wire

/* hw/credit_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module credit_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = exec_pkg::IN_DEPTH
) (
  input  wire                          clk_i,
  input  wire                          reset_i,
  input  wire                          push_i,
  input  payload_t                     data_i,
  input  wire                          pop_i,
  output payload_t                     data_o,
  output logic                         empty_o,
  output logic [$clog2(DEPTH+1)-1:0]   count_o
);

  // depth is a power of two so the pointers wrap on their own
  payload_t                     mem_q [DEPTH];
  logic [$clog2(DEPTH)-1:0]     wr_ptr_q;
  logic [$clog2(DEPTH)-1:0]     rd_ptr_q;
  logic [$clog2(DEPTH+1)-1:0]   count_q;

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // head is visible without a read cycle
  assign data_o  = mem_q[rd_ptr_q];
  assign empty_o = (count_q == '0);
  assign count_o = count_q;

endmodule

`default_nettype wire

/* hw/operand_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module operand_stage (
  input  wire                     clk_i,
  input  wire                     reset_i,
  input  wire                     op_valid_i,
  input  exec_pkg::micro_op_t     op_i,
  output logic                    in_credit_o,
  input  wire                     wb_ready_i,
  input  wire                     mul_busy_i,
  input  wire                     mul_done_i,
  input  exec_pkg::exec_result_t  alu_res_i,
  input  exec_pkg::reg_write_t    wb_write_i,
  output exec_pkg::issue_t        issue_o
);

  exec_pkg::micro_op_t              head;
  logic                             fifo_empty;
  logic                             head_is_mul;
  logic                             hold;
  logic                             pop;
  logic [exec_pkg::XLEN-1:0]        rs1_val;
  logic [exec_pkg::XLEN-1:0]        rs2_val;
  logic [exec_pkg::XLEN-1:0]        regs_q [1 << exec_pkg::REG_BITS];

  credit_fifo #(
    .payload_t (exec_pkg::micro_op_t),
    .DEPTH     (exec_pkg::IN_DEPTH)
  ) in_fifo_i (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .push_i  (op_valid_i),
    .data_i  (op_i),
    .pop_i   (pop),
    .data_o  (head),
    .empty_o (fifo_empty),
    .count_o ()
  );

  ////////////////////////////////////////////////////////////////////
  // register file, x0 never written
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < (1 << exec_pkg::REG_BITS); i++) begin
        regs_q[i] <= '0;
      end
    end else if (wb_write_i.en && wb_write_i.rd != '0) begin
      regs_q[wb_write_i.rd] <= wb_write_i.data;
    end
  end

  // newest value first: alu result, then the write port, then the file
  function automatic logic [exec_pkg::XLEN-1:0] resolve(
    input logic [exec_pkg::REG_BITS-1:0] idx,
    input logic [exec_pkg::XLEN-1:0]     rf_val
  );
    if (idx == '0) begin
      return '0;
    end else if (alu_res_i.valid && alu_res_i.rd == idx) begin
      return alu_res_i.value;
    end else if (wb_write_i.en && wb_write_i.rd == idx) begin
      return wb_write_i.data;
    end
    return rf_val;
  endfunction

  ////////////////////////////////////////////////////////////////////
  // issue control
  ////////////////////////////////////////////////////////////////////

  assign head_is_mul = (head.op == exec_pkg::OP_MUL) || (head.op == exec_pkg::OP_MULHU);

  // a multiply also waits for the alu to drain, so its result
  // always finds room in the output fifo
  assign hold = !wb_ready_i || mul_busy_i || mul_done_i ||
                (head_is_mul && alu_res_i.valid);
  assign pop  = !fifo_empty && !hold;

  always_comb begin
    rs1_val        = resolve(head.rs1, regs_q[head.rs1]);
    rs2_val        = resolve(head.rs2, regs_q[head.rs2]);
    issue_o.valid  = pop;
    issue_o.tag    = head.tag;
    issue_o.op     = head.op;
    issue_o.rd     = head.rd;
    issue_o.opnd_a = rs1_val;
    issue_o.opnd_b = head.use_imm ? head.imm : rs2_val;
  end

  // one credit back per pop, a cycle later
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      in_credit_o <= 1'b0;
    end else begin
      in_credit_o <= pop;
    end
  end

endmodule

`default_nettype wire

/* hw/alu_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
  input  wire                     clk_i,
  input  wire                     reset_i,
  input  exec_pkg::issue_t        issue_i,
  input  wire                     wb_ready_i,
  output exec_pkg::exec_result_t  alu_res_o
);

  logic                       start;
  logic [4:0]                 shamt;
  logic [exec_pkg::XLEN-1:0]  a;
  logic [exec_pkg::XLEN-1:0]  b;
  logic [exec_pkg::XLEN-1:0]  result;
  exec_pkg::exec_result_t     res_q;

  assign start = issue_i.valid && issue_i.op != exec_pkg::OP_MUL &&
                 issue_i.op != exec_pkg::OP_MULHU;
  assign a     = issue_i.opnd_a;
  assign b     = issue_i.opnd_b;
  assign shamt = b[4:0];

  always_comb begin
    case (issue_i.op)
      exec_pkg::OP_ADD:  result = a + b;
      exec_pkg::OP_SUB:  result = a - b;
      exec_pkg::OP_AND:  result = a & b;
      exec_pkg::OP_OR:   result = a | b;
      exec_pkg::OP_XOR:  result = a ^ b;
      exec_pkg::OP_SLL:  result = a << shamt;
      exec_pkg::OP_SRL:  result = a >> shamt;
      exec_pkg::OP_SRA:  result = $signed(a) >>> shamt;
      exec_pkg::OP_SLT:  result = {{(exec_pkg::XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      exec_pkg::OP_SLTU: result = {{(exec_pkg::XLEN-1){1'b0}}, a < b};
      default:           result = '0;
    endcase
  end

  // result stays put until writeback takes it
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      res_q.valid <= 1'b0;
    end else if (start) begin
      res_q <= '{valid: 1'b1, tag: issue_i.tag, rd: issue_i.rd, value: result};
    end else if (wb_ready_i) begin
      res_q.valid <= 1'b0;
    end
  end

  assign alu_res_o = res_q;

endmodule

`default_nettype wire

/* hw/mul_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module mul_unit (
  input  wire                     clk_i,
  input  wire                     reset_i,
  input  exec_pkg::issue_t        issue_i,
  output exec_pkg::exec_result_t  mul_res_o,
  output logic                    busy_o
);

  logic                                   start;
  logic                                   busy_q;
  logic                                   done_q;
  logic                                   hi_q;
  logic [$clog2(exec_pkg::MUL_STEPS)-1:0] step_q;
  logic [2*exec_pkg::XLEN-1:0]            acc_q;
  logic [2*exec_pkg::XLEN-1:0]            mcand_q;
  logic [exec_pkg::XLEN-1:0]              mplier_q;
  logic [exec_pkg::TAG_BITS-1:0]          tag_q;
  logic [exec_pkg::REG_BITS-1:0]          rd_q;

  // four multiplier bits per step
  function automatic logic [2*exec_pkg::XLEN-1:0] partial(
    input logic [2*exec_pkg::XLEN-1:0] mcand,
    input logic [3:0]                  nib
  );
    logic [2*exec_pkg::XLEN-1:0] sum;
    sum = '0;
    for (int i = 0; i < 4; i++) begin
      if (nib[i]) begin
        sum = sum + (mcand << i);
      end
    end
    return sum;
  endfunction

  assign start = issue_i.valid &&
                 (issue_i.op == exec_pkg::OP_MUL || issue_i.op == exec_pkg::OP_MULHU);

  // first nibble is folded in at issue, the other seven while busy
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      step_q <= '0;
    end else if (start) begin
      busy_q   <= 1'b1;
      step_q   <= 1'b1;
      hi_q     <= (issue_i.op == exec_pkg::OP_MULHU);
      tag_q    <= issue_i.tag;
      rd_q     <= issue_i.rd;
      acc_q    <= partial({{exec_pkg::XLEN{1'b0}}, issue_i.opnd_a}, issue_i.opnd_b[3:0]);
      mcand_q  <= {{exec_pkg::XLEN{1'b0}}, issue_i.opnd_a} << 4;
      mplier_q <= issue_i.opnd_b >> 4;
    end else if (busy_q) begin
      if (done_q) begin
        busy_q <= 1'b0;
        done_q <= 1'b0;
      end else begin
        acc_q    <= acc_q + partial(mcand_q, mplier_q[3:0]);
        mcand_q  <= mcand_q << 4;
        mplier_q <= mplier_q >> 4;
        step_q   <= step_q + 1'b1;
        done_q   <= (step_q == ($clog2(exec_pkg::MUL_STEPS))'(exec_pkg::MUL_STEPS - 1));
      end
    end
  end

  assign busy_o    = busy_q;
  assign mul_res_o = '{valid: done_q, tag: tag_q, rd: rd_q,
                       value: hi_q ? acc_q[2*exec_pkg::XLEN-1:exec_pkg::XLEN]
                                   : acc_q[exec_pkg::XLEN-1:0]};

endmodule

`default_nettype wire

/* hw/writeback_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module writeback_stage (
  input  wire                     clk_i,
  input  wire                     reset_i,
  input  exec_pkg::exec_result_t  alu_res_i,
  input  exec_pkg::exec_result_t  mul_res_i,
  output logic                    wb_ready_o,
  output exec_pkg::reg_write_t    wb_write_o,
  input  wire                     out_credit_i,
  output logic                    out_valid_o,
  output exec_pkg::result_t       out_o
);

  logic                                     alu_take;
  logic                                     pend_valid_q;
  exec_pkg::result_t                        pend_q;
  logic                                     out_empty;
  logic [$clog2(exec_pkg::OUT_DEPTH+1)-1:0] out_count;
  logic [exec_pkg::CREDIT_BITS-1:0]         credits_q;

  // multiply results are always taken, issue control leaves room for them
  assign alu_take   = alu_res_i.valid && wb_ready_o;
  assign wb_ready_o = (out_count < ($clog2(exec_pkg::OUT_DEPTH+1))'(exec_pkg::OUT_DEPTH - 1));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pend_valid_q <= 1'b0;
    end else begin
      pend_valid_q <= alu_take || mul_res_i.valid;
      if (mul_res_i.valid) begin
        pend_q <= '{tag: mul_res_i.tag, rd: mul_res_i.rd, value: mul_res_i.value};
      end else if (alu_take) begin
        pend_q <= '{tag: alu_res_i.tag, rd: alu_res_i.rd, value: alu_res_i.value};
      end
    end
  end

  assign wb_write_o = '{en: pend_valid_q && pend_q.rd != '0, rd: pend_q.rd,
                        data: pend_q.value};

  credit_fifo #(
    .payload_t (exec_pkg::result_t),
    .DEPTH     (exec_pkg::OUT_DEPTH)
  ) out_fifo_i (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .push_i  (pend_valid_q),
    .data_i  (pend_q),
    .pop_i   (out_valid_o),
    .data_o  (out_o),
    .empty_o (out_empty),
    .count_o (out_count)
  );

  ////////////////////////////////////////////////////////////////////
  // output credits
  ////////////////////////////////////////////////////////////////////

  assign out_valid_o = !out_empty && credits_q != '0;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      credits_q <= '0;
    end else begin
      case ({out_credit_i, out_valid_o})
        2'b10:   credits_q <= credits_q + 1'b1;
        2'b01:   credits_q <= credits_q - 1'b1;
        default: credits_q <= credits_q;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hw/exec_core.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_core (
  input  wire                  clk_i,
  input  wire                  reset_i,
  input  wire                  op_valid_i,
  input  exec_pkg::micro_op_t  op_i,
  output logic                 in_credit_o,
  input  wire                  out_credit_i,
  output logic                 out_valid_o,
  output exec_pkg::result_t    out_o
);

  exec_pkg::issue_t        issue;
  exec_pkg::exec_result_t  alu_res;
  exec_pkg::exec_result_t  mul_res;
  exec_pkg::reg_write_t    wb_write;
  logic                    mul_busy;
  logic                    wb_ready;

  ////////////////////////////////////////////////////////////////////
  // input side
  ////////////////////////////////////////////////////////////////////

  operand_stage operand_stage_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .op_valid_i  (op_valid_i),
    .op_i        (op_i),
    .in_credit_o (in_credit_o),
    .wb_ready_i  (wb_ready),
    .mul_busy_i  (mul_busy),
    .mul_done_i  (mul_res.valid),
    .alu_res_i   (alu_res),
    .wb_write_i  (wb_write),
    .issue_o     (issue)
  );

  // processing units
  alu_unit alu_unit_i (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .issue_i    (issue),
    .wb_ready_i (wb_ready),
    .alu_res_o  (alu_res)
  );

  mul_unit mul_unit_i (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .issue_i   (issue),
    .mul_res_o (mul_res),
    .busy_o    (mul_busy)
  );

  ////////////////////////////////////////////////////////////////////
  // output side
  ////////////////////////////////////////////////////////////////////

  writeback_stage writeback_stage_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .alu_res_i    (alu_res),
    .mul_res_i    (mul_res),
    .wb_ready_o   (wb_ready),
    .wb_write_o   (wb_write),
    .out_credit_i (out_credit_i),
    .out_valid_o  (out_valid_o),
    .out_o        (out_o)
  );

endmodule

`default_nettype wire

/* verif/exec_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_core_tb;

  localparam int PERIOD      = 40;
  localparam int HOLD_CYCLES = 60;
  localparam int N_OPS       = 32 + 40 + 24 + 40 + 12;
  // one op at a time through the multiplier and a full output fifo
  localparam int OP_WORST    = exec_pkg::MUL_STEPS + 2 * exec_pkg::OUT_DEPTH + 8;
  localparam int CYCLE_LIMIT = 2 * (N_OPS * OP_WORST + HOLD_CYCLES + 20);

  logic                 clk_i = 1'b0;
  logic                 reset_i;
  logic                 op_valid_i;
  exec_pkg::micro_op_t  op_i;
  logic                 in_credit_o;
  logic                 out_credit_i;
  logic                 out_valid_o;
  exec_pkg::result_t    out_o;

  exec_pkg::micro_op_t  send_q [$];
  exec_pkg::result_t    expect_q [$];
  logic [31:0]          model_regs [32];
  logic [7:0]           next_tag;
  integer               seed;
  int                   errors;
  int                   checks;
  int                   in_credits;
  int                   sent;
  int                   returned;
  int                   out_credits;
  int                   records;
  bit                   grant_en;
  int                   cycles = 0;

  exec_core exec_core_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .op_valid_i   (op_valid_i),
    .op_i         (op_i),
    .in_credit_o  (in_credit_o),
    .out_credit_i (out_credit_i),
    .out_valid_o  (out_valid_o),
    .out_o        (out_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(PERIOD / 2) clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, %0d records never arrived", cycles, expect_q.size());
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // a reset cycle leaves both handshake outputs low
  assert property (@(posedge clk_i) reset_i |=> (!in_credit_o && !out_valid_o))
    else begin
      errors++;
      $display("** Error at %0t: in_credit_o = %b, out_valid_o = %b, expected 0 after reset",
               $time, in_credit_o, out_valid_o);
    end

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] model_result(
    input exec_pkg::alu_op_e op,
    input logic [31:0]       a,
    input logic [31:0]       b
  );
    logic [63:0] prod;
    prod = {32'd0, a} * {32'd0, b};
    case (op)
      exec_pkg::OP_ADD:   return a + b;
      exec_pkg::OP_SUB:   return a - b;
      exec_pkg::OP_AND:   return a & b;
      exec_pkg::OP_OR:    return a | b;
      exec_pkg::OP_XOR:   return a ^ b;
      exec_pkg::OP_SLL:   return a << b[4:0];
      exec_pkg::OP_SRL:   return a >> b[4:0];
      exec_pkg::OP_SRA:   return $signed(a) >>> b[4:0];
      exec_pkg::OP_SLT:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      exec_pkg::OP_SLTU:  return (a < b) ? 32'd1 : 32'd0;
      exec_pkg::OP_MUL:   return prod[31:0];
      exec_pkg::OP_MULHU: return prod[63:32];
      default:            return 32'd0;
    endcase
  endfunction

  function automatic exec_pkg::alu_op_e pick_alu_op();
    logic [31:0] r;
    r = $random(seed);
    return exec_pkg::alu_op_e'(4'(r % 32'd10));
  endfunction

  // expected record computed in program order
  task automatic queue_op(
    input exec_pkg::alu_op_e op,
    input logic [4:0]        rd,
    input logic [4:0]        rs1,
    input logic [4:0]        rs2,
    input logic              use_imm,
    input logic [31:0]       imm
  );
    exec_pkg::micro_op_t m;
    exec_pkg::result_t   r;
    logic [31:0]         b;
    b = use_imm ? imm : model_regs[rs2];
    m = '{tag: next_tag, op: op, rd: rd, rs1: rs1, rs2: rs2, use_imm: use_imm, imm: imm};
    r = '{tag: next_tag, rd: rd, value: model_result(op, model_regs[rs1], b)};
    send_q.push_back(m);
    expect_q.push_back(r);
    if (rd != 5'd0) begin
      model_regs[rd] = r.value;
    end
    next_tag++;
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] want);
    checks++;
    assert (got === want) else begin
      errors++;
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, want);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // one clock cycle: sample on the falling edge, then drive
  //////////////////////////////////////////////////////////////////////

  task automatic cycle();
    exec_pkg::result_t exp;
    @(negedge clk_i);
    if (in_credit_o) begin
      in_credits++;
      returned++;
    end
    // a credit may only come back for an operation already sent
    assert (returned <= sent) else begin
      errors++;
      $display("in_credit_o returned more credits than operations sent at %0t", $time);
    end
    if (out_valid_o) begin
      checks++;
      assert (out_credits > 0) else begin
        errors++;
        $display("out_valid_o high at %0t without an output credit", $time);
      end
      out_credits--;
      records++;
      if (expect_q.size() == 0) begin
        errors++;
        $display("unexpected record at %0t with tag %h", $time, out_o.tag);
      end else begin
        exp = expect_q.pop_front();
        check_value("out_o.tag", out_o.tag, exp.tag);
        check_value("out_o.rd", out_o.rd, exp.rd);
        check_value("out_o.value", out_o.value, exp.value);
      end
    end
    out_credit_i = grant_en && out_credits < 3;
    if (out_credit_i) begin
      out_credits++;
    end
    op_valid_i = 1'b0;
    if (send_q.size() > 0 && in_credits > 0) begin
      op_i = send_q.pop_front();
      op_valid_i = 1'b1;
      in_credits--;
      sent++;
    end
  endtask

  task automatic drain();
    while (send_q.size() > 0 || expect_q.size() > 0) begin
      cycle();
    end
    repeat (4) cycle();
  endtask

  //////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////

  initial begin
    int          base;
    int          held;
    int          start_records;
    logic [31:0] rnd;
    logic [4:0]  prev;
    logic [4:0]  prev2;
    logic [4:0]  dst;
    seed         = 55;
    reset_i      = 1'b1;
    op_valid_i   = 1'b0;
    op_i         = '0;
    out_credit_i = 1'b0;
    errors       = 0;
    checks       = 0;
    in_credits   = exec_pkg::IN_DEPTH;
    sent         = 0;
    returned     = 0;
    out_credits  = 0;
    records      = 0;
    grant_en     = 1'b0;
    next_tag     = 8'd0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = 32'd0;
    end
    repeat (2) @(negedge clk_i);
    reset_i  = 1'b0;
    grant_en = 1'b1;

    // reset state, every register reads zero
    base = errors;
    repeat (6) begin
      cycle();
      checks++;
      assert (!in_credit_o && !out_valid_o) else begin
        errors++;
        $display("** Error at %0t: in_credit_o = %b, out_valid_o = %b, expected 0",
                 $time, in_credit_o, out_valid_o);
      end
    end
    for (int r = 0; r < 32; r++) begin
      queue_op(exec_pkg::OP_OR, 5'd0, 5'(r), 5'(r), 1'b0, 32'd0);
    end
    drain();
    $display("test 1 reset state: %0d errors", errors - base);

    // random alu ops with and without immediates
    base = errors;
    repeat (40) begin
      rnd = $random(seed);
      queue_op(pick_alu_op(), rnd[4:0], rnd[9:5], rnd[14:10], rnd[15], $random(seed));
    end
    drain();
    $display("test 2 alu and immediates: %0d errors", errors - base);

    // dependent chains, every sixth op aims at x0
    base  = errors;
    prev  = 5'd1;
    prev2 = 5'd2;
    for (int i = 0; i < 24; i++) begin
      rnd = $random(seed);
      dst = (i % 6 == 5) ? 5'd0 : 5'(1 + i % 8);
      queue_op(pick_alu_op(), dst, prev, prev2, rnd[0], $random(seed));
      prev2 = prev;
      prev  = dst;
    end
    drain();
    $display("test 3 forwarding: %0d errors", errors - base);

    // mul and mulhu with alu ops around them
    base = errors;
    for (int k = 0; k < 10; k++) begin
      queue_op(exec_pkg::OP_ADD, 5'd10, 5'd0, 5'd0, 1'b1, $random(seed));
      queue_op(exec_pkg::OP_ADD, 5'd11, 5'd0, 5'd0, 1'b1, $random(seed));
      queue_op(k[0] ? exec_pkg::OP_MULHU : exec_pkg::OP_MUL, 5'd12, 5'd10, 5'd11,
               k[1], $random(seed));
      queue_op(exec_pkg::OP_XOR, 5'd13, 5'd12, 5'd10, 1'b0, 32'd0);
    end
    drain();
    $display("test 4 multiply: %0d errors", errors - base);

    // every op sent came back as an input credit
    base = errors;
    checks++;
    assert (returned == sent) else begin
      errors++;
      $display("** Error at %0t: in_credit_o pulses = %0d, expected %0d", $time, returned, sent);
    end
    $display("test 5 credit accounting: %0d errors", errors - base);

    // output credits withheld while 12 ops go in
    base          = errors;
    grant_en      = 1'b0;
    held          = out_credits;
    start_records = records;
    repeat (12) begin
      rnd = $random(seed);
      queue_op(pick_alu_op(), rnd[4:0], rnd[9:5], rnd[14:10], rnd[15], $random(seed));
    end
    repeat (HOLD_CYCLES) cycle();
    checks++;
    assert (records - start_records <= held) else begin
      errors++;
      $display("%0d records left with only %0d credits granted", records - start_records, held);
    end
    grant_en = 1'b1;
    drain();
    check_value("record count", records - start_records, 32'd12);
    $display("test 6 back-pressure: %0d errors", errors - base);

    $display("checks %0d, errors %0d, ops sent %0d, records %0d", checks, errors, sent, records);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
hw/exec_pkg.sv
hw/credit_fifo.sv
hw/operand_stage.sv
hw/alu_unit.sv
hw/mul_unit.sv
hw/writeback_stage.sv
hw/exec_core.sv
verif/exec_core_tb.sv
